//--- client_cfg_regs.sv
// -------------------------------------------------
// writable configuration words that update one cycle after the write pulse
// counter-clear bit drops by itself after PC_CLR_HOLD cycles
// -------------------------------------------------
`include "pkt_client_cfg.svh"

module client_cfg_regs
    import pkt_client_pkg::*;
(
    input  logic                    i_clk_status,
    input  logic                    i_clk_status_rst,
    input  bus_req_t                i_req,
    output cfg_regs_t               o_regs,
    output logic [`PC_CTRL_W-1:0]   o_cfg_pkt_client_ctrl,
    output logic [47:0]             o_dyn_dmac_addr,
    output logic [47:0]             o_dyn_smac_addr,
    output logic [31:0]             o_dyn_pkt_num,
    output logic [13:0]             o_dyn_pkt_start_size,
    output logic [13:0]             o_dyn_pkt_end_size,
    output logic                    o_cold_rst_csr,
    output logic                    o_stat_cntr_snapshot,
    output logic                    o_stat_cntr_clear,
    output logic                    o_stat_cnt_clr
);

    logic [`PC_CLR_HOLD-2:0] clr_sr;   // age of the counter-clear bit

    // -----------------------------------------------
    // register file
    // -----------------------------------------------
    always_ff @(posedge i_clk_status) begin
        if (i_clk_status_rst) begin
            o_regs.ctrl     <= '0;
            o_regs.dmac_hi  <= `PC_RST_REG03;
            o_regs.dmac_lo  <= `PC_RST_REG04;
            o_regs.smac_hi  <= `PC_RST_REG05;
            o_regs.smac_lo  <= `PC_RST_REG06;
            o_regs.pkt_num  <= `PC_RST_REG07;
            o_regs.pkt_size <= `PC_RST_REG08;
            o_regs.cold_rst <= '0;
            clr_sr          <= '0;
        end else begin
            clr_sr <= {clr_sr[`PC_CLR_HOLD-3:0], o_regs.ctrl[`PC_CTRL_CNT_CLR]};
            if (clr_sr[`PC_CLR_HOLD-2])
                o_regs.ctrl[`PC_CTRL_CNT_CLR] <= 1'b0;
            // a write wins over the self-clear
            if (i_req.wr) begin
                case (i_req.idx)
                    CTRL: begin
                        o_regs.ctrl <= i_req.wdata;
                        clr_sr      <= '0;   // restart hold count
                    end
                    DMAC_HI:  o_regs.dmac_hi  <= i_req.wdata;
                    DMAC_LO:  o_regs.dmac_lo  <= i_req.wdata;
                    SMAC_HI:  o_regs.smac_hi  <= i_req.wdata;
                    SMAC_LO:  o_regs.smac_lo  <= i_req.wdata;
                    PKT_NUM:  o_regs.pkt_num  <= i_req.wdata;
                    PKT_SIZE: o_regs.pkt_size <= i_req.wdata;
                    COLD_RST: o_regs.cold_rst <= i_req.wdata;
                    default: ;   // counters and holes are read only
                endcase
            end
        end
    end

    // -----------------------------------------------
    // field outputs
    // -----------------------------------------------
    assign o_cfg_pkt_client_ctrl = o_regs.ctrl[`PC_CTRL_W-1:0];
    assign o_dyn_dmac_addr       = {o_regs.dmac_hi[15:0], o_regs.dmac_lo};
    assign o_dyn_smac_addr       = {o_regs.smac_hi[15:0], o_regs.smac_lo};
    assign o_dyn_pkt_num         = o_regs.pkt_num;
    assign o_dyn_pkt_start_size  = o_regs.pkt_size[13:0];
    assign o_dyn_pkt_end_size    = o_regs.pkt_size[29:16];
    assign o_cold_rst_csr        = o_regs.cold_rst[0];
    assign o_stat_cntr_snapshot  = o_regs.ctrl[`PC_CTRL_SNAPSHOT];
    assign o_stat_cntr_clear     = o_regs.ctrl[`PC_CTRL_SHADOW_CLR];
    assign o_stat_cnt_clr        = o_regs.ctrl[`PC_CTRL_CNT_CLR];

    // clear bit must not stick unless the host writes ctrl again
    a_clr_drops: assert property (@(posedge i_clk_status)
        disable iff (i_clk_status_rst || (i_req.wr && i_req.idx == CTRL))
        $rose(o_stat_cnt_clr) |-> ##[1:(`PC_CLR_HOLD + 1)] !o_stat_cnt_clr);

endmodule

//--- flist.f
+incdir+.
pkt_client_pkg.sv
status_bus_front.sv
client_cfg_regs.sv
pkt_stat_bank.sv
status_readback.sv
pkt_client_csr.sv
tb_pkt_client_csr.sv

//--- pkt_client_cfg.svh
// -------------------------------------------------
// widths, address fields and reset values of the csr block
// index field is addr[7:2], base compared on addr[15:8]
// PC_CLR_HOLD must be at least 3
// -------------------------------------------------
`ifndef PKT_CLIENT_CFG_SVH
`define PKT_CLIENT_CFG_SVH

// status bus
`define PC_DATA_W           32
`define PC_ADDR_W           23
`define PC_BASE_ADDR        32'h0000_0000
`define PC_IDX_MSB          7
`define PC_IDX_LSB          2

// statistics
`define PC_CNT_W            64
`define PC_INC_W            8

// control word, reg 0x00
`define PC_CTRL_W           20
`define PC_CTRL_START       0   // packet generator run
`define PC_CTRL_LOOPBACK    4   // loopback data to mac
`define PC_CTRL_SNAPSHOT    6
`define PC_CTRL_SHADOW_CLR  7
`define PC_CTRL_CNT_CLR     8   // self-clearing
`define PC_CLR_HOLD         8

// reset values
`define PC_RST_REG03        32'h0000_1234
`define PC_RST_REG04        32'h5678_0ADD
`define PC_RST_REG05        32'h0000_8765
`define PC_RST_REG06        32'h4321_0ADD
`define PC_RST_REG07        32'h0000_000A
`define PC_RST_REG08        32'h2580_0040

`define PC_UNMAPPED_DATA    32'hDEAD_C0DE

`endif

//--- pkt_client_csr.sv
// -------------------------------------------------
// csr block of the packet client, status clock domain only
// one request in flight, back-pressure by waitrequest
// -------------------------------------------------
`include "pkt_client_cfg.svh"

module pkt_client_csr
    import pkt_client_pkg::*;
(
    input  logic                    i_clk_status,
    input  logic                    i_clk_status_rst,
    // status bus
    input  logic [`PC_ADDR_W-1:0]   i_status_addr,
    input  logic                    i_status_read,
    input  logic                    i_status_write,
    input  logic [`PC_DATA_W-1:0]   i_status_writedata,
    output logic [`PC_DATA_W-1:0]   o_status_readdata,
    output logic                    o_status_readdata_valid,
    output logic                    o_status_waitrequest,
    // configuration
    output logic [`PC_CTRL_W-1:0]   o_cfg_pkt_client_ctrl,
    output logic [47:0]             o_dyn_dmac_addr,
    output logic [47:0]             o_dyn_smac_addr,
    output logic [31:0]             o_dyn_pkt_num,
    output logic [13:0]             o_dyn_pkt_start_size,
    output logic [13:0]             o_dyn_pkt_end_size,
    output logic                    o_cold_rst_csr,
    output logic                    o_stat_cntr_snapshot,
    output logic                    o_stat_cntr_clear,
    output logic                    o_stat_cnt_clr,
    // statistics
    input  stat_incr_t              i_tx_stat,
    input  stat_incr_t              i_rx_stat
);

    bus_req_t      req;
    cfg_regs_t     regs;
    stat_shadow_t  shadow;

    status_bus_front front_i (
        .i_clk_status, .i_clk_status_rst,
        .i_status_addr, .i_status_read, .i_status_write, .i_status_writedata,
        .o_req                (req),
        .o_status_waitrequest
    );

    client_cfg_regs regs_i (
        .i_clk_status, .i_clk_status_rst,
        .i_req                (req),
        .o_regs               (regs),
        .o_cfg_pkt_client_ctrl, .o_dyn_dmac_addr, .o_dyn_smac_addr,
        .o_dyn_pkt_num, .o_dyn_pkt_start_size, .o_dyn_pkt_end_size,
        .o_cold_rst_csr, .o_stat_cntr_snapshot, .o_stat_cntr_clear,
        .o_stat_cnt_clr
    );

    pkt_stat_bank stat_i (
        .i_clk_status, .i_clk_status_rst,
        .i_tx_stat, .i_rx_stat,
        .i_snapshot           (o_stat_cntr_snapshot),
        .i_shadow_clr         (o_stat_cntr_clear),
        .i_cnt_clr            (o_stat_cnt_clr),
        .o_shadow             (shadow)
    );

    status_readback rdbk_i (
        .i_clk_status, .i_clk_status_rst,
        .i_req                (req),
        .i_regs               (regs),
        .i_shadow             (shadow),
        .o_status_readdata, .o_status_readdata_valid
    );

endmodule

//--- pkt_client_pkg.sv
// -------------------------------------------------
// register map and bundle types of the csr block
// -------------------------------------------------
`include "pkt_client_cfg.svh"

package pkt_client_pkg;

    // word index, address bits 7:2
    typedef enum logic [`PC_IDX_MSB-`PC_IDX_LSB:0] {
        CTRL      = 6'h00,
        DMAC_HI   = 6'h03,
        DMAC_LO   = 6'h04,
        SMAC_HI   = 6'h05,
        SMAC_LO   = 6'h06,
        PKT_NUM   = 6'h07,
        PKT_SIZE  = 6'h08,
        TX_SOP_LO = 6'h09,
        TX_SOP_HI = 6'h0A,
        TX_EOP_LO = 6'h0B,
        TX_EOP_HI = 6'h0C,
        TX_ERR_LO = 6'h0D,
        TX_ERR_HI = 6'h0E,
        RX_SOP_LO = 6'h0F,
        RX_SOP_HI = 6'h10,
        RX_EOP_LO = 6'h11,
        RX_EOP_HI = 6'h12,
        RX_ERR_LO = 6'h13,
        RX_ERR_HI = 6'h14,
        COLD_RST  = 6'h20
    } csr_reg_e;

    // accepted request, strobes one cycle wide
    typedef struct packed {
        csr_reg_e                idx;
        logic [`PC_DATA_W-1:0]   wdata;
        logic                    rd;
        logic                    wr;
    } bus_req_t;

    typedef struct packed {
        logic [`PC_DATA_W-1:0]   ctrl;
        logic [`PC_DATA_W-1:0]   dmac_hi;   // bits 15:0 used
        logic [`PC_DATA_W-1:0]   dmac_lo;
        logic [`PC_DATA_W-1:0]   smac_hi;   // bits 15:0 used
        logic [`PC_DATA_W-1:0]   smac_lo;
        logic [`PC_DATA_W-1:0]   pkt_num;
        logic [`PC_DATA_W-1:0]   pkt_size;  // end 29:16, start 13:0
        logic [`PC_DATA_W-1:0]   cold_rst;
    } cfg_regs_t;

    // one beat of per-direction statistics
    typedef struct packed {
        logic                    valid;
        logic [`PC_INC_W-1:0]    sop;
        logic [`PC_INC_W-1:0]    eop;
        logic [`PC_INC_W-1:0]    err;
    } stat_incr_t;

    typedef struct packed {
        logic [`PC_CNT_W-1:0]    tx_sop;
        logic [`PC_CNT_W-1:0]    tx_eop;
        logic [`PC_CNT_W-1:0]    tx_err;
        logic [`PC_CNT_W-1:0]    rx_sop;
        logic [`PC_CNT_W-1:0]    rx_eop;
        logic [`PC_CNT_W-1:0]    rx_err;
    } stat_shadow_t;

endpackage

//--- pkt_stat_bank.sv
// -------------------------------------------------
// six packet statistic accumulators with frozen shadow copies
// shadow-clear wins over snapshot, counters wrap at 2**64
// -------------------------------------------------
`include "pkt_client_cfg.svh"

module pkt_stat_bank
    import pkt_client_pkg::*;
(
    input  logic           i_clk_status,
    input  logic           i_clk_status_rst,
    input  stat_incr_t     i_tx_stat,
    input  stat_incr_t     i_rx_stat,
    input  logic           i_snapshot,
    input  logic           i_shadow_clr,
    input  logic           i_cnt_clr,
    output stat_shadow_t   o_shadow
);

    localparam int NCNT = 6;

    logic [`PC_INC_W-1:0]  inc [NCNT];
    logic                  vld [NCNT];
    logic [`PC_CNT_W-1:0]  acc [NCNT];
    logic [`PC_CNT_W-1:0]  sh  [NCNT];

    // order tx sop, eop, err then rx
    assign inc = '{i_tx_stat.sop, i_tx_stat.eop, i_tx_stat.err,
                   i_rx_stat.sop, i_rx_stat.eop, i_rx_stat.err};
    assign vld = '{i_tx_stat.valid, i_tx_stat.valid, i_tx_stat.valid,
                   i_rx_stat.valid, i_rx_stat.valid, i_rx_stat.valid};

    // -----------------------------------------------
    // accumulate and shadow
    // -----------------------------------------------
    always_ff @(posedge i_clk_status) begin
        for (int i = 0; i < NCNT; i++) begin
            if (i_clk_status_rst || i_cnt_clr)
                acc[i] <= '0;
            else if (vld[i])
                acc[i] <= acc[i] + {{(`PC_CNT_W-`PC_INC_W){1'b0}}, inc[i]};

            if (i_clk_status_rst || i_shadow_clr)
                sh[i] <= '0;
            else if (!i_snapshot)
                sh[i] <= acc[i];   // frozen while snapshot set
        end
    end

    assign o_shadow = '{tx_sop: sh[0], tx_eop: sh[1], tx_err: sh[2],
                        rx_sop: sh[3], rx_eop: sh[4], rx_err: sh[5]};

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the csr testbench with verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_pkt_client_csr \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

//--- status_bus_front.sv
// -------------------------------------------------
// host holds a request until waitrequest drops, then releases it
// off-base requests are never answered
// -------------------------------------------------
`include "pkt_client_cfg.svh"

module status_bus_front
    import pkt_client_pkg::*;
(
    input  logic                    i_clk_status,
    input  logic                    i_clk_status_rst,
    input  logic [`PC_ADDR_W-1:0]   i_status_addr,
    input  logic                    i_status_read,
    input  logic                    i_status_write,
    input  logic [`PC_DATA_W-1:0]   i_status_writedata,
    output bus_req_t                o_req,
    output logic                    o_status_waitrequest
);

    localparam logic [`PC_DATA_W-1:0] BASE = `PC_BASE_ADDR;

    csr_reg_e                idx_r;
    logic [`PC_DATA_W-1:0]   wdata_r;
    logic                    addr_hit;
    logic                    rd_r, wr_r;
    logic                    rd_r2, wr_r2;
    logic                    rd_edge, wr_edge;

    assign addr_hit = (i_status_addr[15:8] == BASE[15:8]);

    assign rd_edge  = rd_r & ~rd_r2;   // held strobe taken once
    assign wr_edge  = wr_r & ~wr_r2;

    // -----------------------------------------------
    // capture and edge detect
    // -----------------------------------------------
    always_ff @(posedge i_clk_status) begin
        idx_r       <= csr_reg_e'(i_status_addr[`PC_IDX_MSB:`PC_IDX_LSB]);
        wdata_r     <= i_status_writedata;
        o_req.idx   <= idx_r;
        o_req.wdata <= wdata_r;
        if (i_clk_status_rst) begin
            rd_r                 <= 1'b0;
            wr_r                 <= 1'b0;
            rd_r2                <= 1'b0;
            wr_r2                <= 1'b0;
            o_req.rd             <= 1'b0;
            o_req.wr             <= 1'b0;
            o_status_waitrequest <= 1'b1;
        end else begin
            rd_r                 <= i_status_read & addr_hit;
            wr_r                 <= i_status_write & addr_hit;
            rd_r2                <= rd_r;
            wr_r2                <= wr_r;
            o_req.rd             <= rd_edge;
            o_req.wr             <= wr_edge;
            o_status_waitrequest <= ~(rd_edge | wr_edge);   // low with the pulse
        end
    end

    // -----------------------------------------------
    // checks
    // -----------------------------------------------
    a_one_strobe: assert property (@(posedge i_clk_status) disable iff (i_clk_status_rst)
        !(o_req.rd && o_req.wr));

    a_wait_single: assert property (@(posedge i_clk_status) disable iff (i_clk_status_rst)
        !o_status_waitrequest |=> o_status_waitrequest);

endmodule

//--- status_readback.sv
// -------------------------------------------------
// registered readback, data held until the next read
// unmapped indices return PC_UNMAPPED_DATA
// -------------------------------------------------
`include "pkt_client_cfg.svh"

module status_readback
    import pkt_client_pkg::*;
(
    input  logic                    i_clk_status,
    input  logic                    i_clk_status_rst,
    input  bus_req_t                i_req,
    input  cfg_regs_t               i_regs,
    input  stat_shadow_t            i_shadow,
    output logic [`PC_DATA_W-1:0]   o_status_readdata,
    output logic                    o_status_readdata_valid
);

    always_ff @(posedge i_clk_status) begin
        if (i_clk_status_rst)
            o_status_readdata_valid <= 1'b0;
        else
            o_status_readdata_valid <= i_req.rd;

        if (i_req.rd) begin
            case (i_req.idx)
                CTRL:      o_status_readdata <= i_regs.ctrl;
                DMAC_HI:   o_status_readdata <= i_regs.dmac_hi;
                DMAC_LO:   o_status_readdata <= i_regs.dmac_lo;
                SMAC_HI:   o_status_readdata <= i_regs.smac_hi;
                SMAC_LO:   o_status_readdata <= i_regs.smac_lo;
                PKT_NUM:   o_status_readdata <= i_regs.pkt_num;
                PKT_SIZE:  o_status_readdata <= i_regs.pkt_size;
                // counters, low word first
                TX_SOP_LO: o_status_readdata <= i_shadow.tx_sop[31:0];
                TX_SOP_HI: o_status_readdata <= i_shadow.tx_sop[63:32];
                TX_EOP_LO: o_status_readdata <= i_shadow.tx_eop[31:0];
                TX_EOP_HI: o_status_readdata <= i_shadow.tx_eop[63:32];
                TX_ERR_LO: o_status_readdata <= i_shadow.tx_err[31:0];
                TX_ERR_HI: o_status_readdata <= i_shadow.tx_err[63:32];
                RX_SOP_LO: o_status_readdata <= i_shadow.rx_sop[31:0];
                RX_SOP_HI: o_status_readdata <= i_shadow.rx_sop[63:32];
                RX_EOP_LO: o_status_readdata <= i_shadow.rx_eop[31:0];
                RX_EOP_HI: o_status_readdata <= i_shadow.rx_eop[63:32];
                RX_ERR_LO: o_status_readdata <= i_shadow.rx_err[31:0];
                RX_ERR_HI: o_status_readdata <= i_shadow.rx_err[63:32];
                COLD_RST:  o_status_readdata <= i_regs.cold_rst;
                default:   o_status_readdata <= `PC_UNMAPPED_DATA;
            endcase
        end
    end

endmodule

//--- tb_pkt_client_csr.sv
// -------------------------------------------------
// testbench of the csr block with one bus request at a time
// counter totals stay below 2**32, so high halves read zero
// -------------------------------------------------
`include "pkt_client_cfg.svh"

module tb_pkt_client_csr
    import pkt_client_pkg::*;
;

    localparam int N_OPS   = 220;   // planned bus operations and beats
    localparam int WD_TIME = (N_OPS * 20 + 200) * 100;

    logic                    clk;
    logic                    rst;
    logic [`PC_ADDR_W-1:0]   status_addr;
    logic                    status_read;
    logic                    status_write;
    logic [`PC_DATA_W-1:0]   status_writedata;
    logic [`PC_DATA_W-1:0]   status_readdata;
    logic                    status_readdata_valid;
    logic                    status_waitrequest;
    logic [`PC_CTRL_W-1:0]   cfg_ctrl;
    logic [47:0]             dmac_addr;
    logic [47:0]             smac_addr;
    logic [31:0]             pkt_num;
    logic [13:0]             pkt_start_size;
    logic [13:0]             pkt_end_size;
    logic                    cold_rst;
    logic                    cntr_snapshot;
    logic                    cntr_clear;
    logic                    cnt_clr;
    stat_incr_t              tx_stat;
    stat_incr_t              rx_stat;

    // reference model
    logic [31:0]             cfg_m [64];
    logic [63:0]             acc_m [6];
    logic [63:0]             sh_m  [6];
    logic                    snap_m;
    logic                    shclr_m;
    csr_reg_e                cfg_list [8];
    logic [31:0]             lcg_state;
    logic [31:0]             exp_q [$];
    string                   name_q [$];
    int                      value_errs;
    int                      proto_errs;

    pkt_client_csr dut_i (
        .i_clk_status            (clk),
        .i_clk_status_rst        (rst),
        .i_status_addr           (status_addr),
        .i_status_read           (status_read),
        .i_status_write          (status_write),
        .i_status_writedata      (status_writedata),
        .o_status_readdata       (status_readdata),
        .o_status_readdata_valid (status_readdata_valid),
        .o_status_waitrequest    (status_waitrequest),
        .o_cfg_pkt_client_ctrl   (cfg_ctrl),
        .o_dyn_dmac_addr         (dmac_addr),
        .o_dyn_smac_addr         (smac_addr),
        .o_dyn_pkt_num           (pkt_num),
        .o_dyn_pkt_start_size    (pkt_start_size),
        .o_dyn_pkt_end_size      (pkt_end_size),
        .o_cold_rst_csr          (cold_rst),
        .o_stat_cntr_snapshot    (cntr_snapshot),
        .o_stat_cntr_clear       (cntr_clear),
        .o_stat_cnt_clr          (cnt_clr),
        .i_tx_stat               (tx_stat),
        .i_rx_stat               (rx_stat)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------------------------------------
    // helpers and reference functions
    // --------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [`PC_ADDR_W-1:0] reg_addr(csr_reg_e idx);
        logic [`PC_ADDR_W-1:0] a;
        logic [31:0]           base;
        base                       = `PC_BASE_ADDR;
        a                          = '0;
        a[15:8]                    = base[15:8];
        a[`PC_IDX_MSB:`PC_IDX_LSB] = idx;
        return a;
    endfunction

    function automatic bit is_cfg(csr_reg_e idx);
        case (idx)
            CTRL, DMAC_HI, DMAC_LO, SMAC_HI, SMAC_LO, PKT_NUM, PKT_SIZE, COLD_RST: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // value a read of idx must return
    function automatic logic [31:0] expect_reg(csr_reg_e idx);
        int k;
        k = int'(idx) - int'(TX_SOP_LO);
        if (is_cfg(idx))
            return cfg_m[idx];
        if (k >= 0 && k < 12)
            return ((k % 2) == 1) ? sh_m[k / 2][63:32] : sh_m[k / 2][31:0];
        return `PC_UNMAPPED_DATA;
    endfunction

    task automatic reset_model();
        foreach (cfg_m[i]) cfg_m[i] = '0;
        cfg_m[DMAC_HI]  = `PC_RST_REG03;
        cfg_m[DMAC_LO]  = `PC_RST_REG04;
        cfg_m[SMAC_HI]  = `PC_RST_REG05;
        cfg_m[SMAC_LO]  = `PC_RST_REG06;
        cfg_m[PKT_NUM]  = `PC_RST_REG07;
        cfg_m[PKT_SIZE] = `PC_RST_REG08;
        foreach (acc_m[i]) acc_m[i] = '0;
        foreach (sh_m[i]) sh_m[i] = '0;
        snap_m  = 1'b0;
        shclr_m = 1'b0;
    endtask

    // shadows after the bank has had time to follow
    task automatic settle_model();
        foreach (sh_m[i]) begin
            if (shclr_m)
                sh_m[i] = '0;
            else if (!snap_m)
                sh_m[i] = acc_m[i];
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    // configuration outputs against the model words
    task automatic verify_field_outputs();
        check_val("o_cfg_pkt_client_ctrl", 64'(cfg_ctrl), 64'(cfg_m[CTRL][`PC_CTRL_W-1:0]));
        check_val("o_dyn_dmac_addr", 64'(dmac_addr), 64'({cfg_m[DMAC_HI][15:0], cfg_m[DMAC_LO]}));
        check_val("o_dyn_smac_addr", 64'(smac_addr), 64'({cfg_m[SMAC_HI][15:0], cfg_m[SMAC_LO]}));
        check_val("o_dyn_pkt_num", 64'(pkt_num), 64'(cfg_m[PKT_NUM]));
        check_val("o_dyn_pkt_start_size", 64'(pkt_start_size), 64'(cfg_m[PKT_SIZE][13:0]));
        check_val("o_dyn_pkt_end_size", 64'(pkt_end_size), 64'(cfg_m[PKT_SIZE][29:16]));
        check_val("o_cold_rst_csr", 64'(cold_rst), 64'(cfg_m[COLD_RST][0]));
    endtask

    // hold the request until wait-request drops, then release it
    task automatic bus_access(input bit is_wr, input csr_reg_e idx, input logic [31:0] data);
        int n;
        @(negedge clk);
        status_addr      = reg_addr(idx);
        status_write     = is_wr;
        status_read      = !is_wr;
        status_writedata = data;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (status_waitrequest && n < 10);
        assert (!status_waitrequest) else begin
            proto_errs++;
            $display("no wait-request low for access to index %0h at %0t", idx, $time);
        end
        if (!status_waitrequest)
            check_val("o_status_waitrequest latency", 64'(n), 64'd2);
        status_read  = 1'b0;
        status_write = 1'b0;
    endtask

    task automatic bus_write(input csr_reg_e idx, input logic [31:0] data);
        bus_access(1'b1, idx, data);
        @(negedge clk);   // request gap
        if (is_cfg(idx))
            cfg_m[idx] = data;
        if (idx == CTRL) begin
            snap_m  = data[`PC_CTRL_SNAPSHOT];
            shclr_m = data[`PC_CTRL_SHADOW_CLR];
            if (data[`PC_CTRL_CNT_CLR]) begin
                foreach (acc_m[i]) acc_m[i] = '0;
                cfg_m[CTRL][`PC_CTRL_CNT_CLR] = 1'b0;   // self-clears later
            end
        end
        settle_model();
    endtask

    task automatic bus_read(input csr_reg_e idx);
        int n;
        exp_q.push_back(expect_reg(idx));
        name_q.push_back($sformatf("o_status_readdata[idx %0h]", idx));
        bus_access(1'b0, idx, '0);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!status_readdata_valid && n < 10);
        assert (status_readdata_valid) else begin
            proto_errs++;
            $display("read of index %0h got no valid pulse at %0t", idx, $time);
            exp_q.delete();
            name_q.delete();
        end
    endtask

    task automatic read_counters();
        for (int i = 9; i <= 20; i++)
            bus_read(csr_reg_e'(i));
    endtask

    task automatic drive_beats(input int n);
        logic [31:0] r;
        for (int b = 0; b < n; b++) begin
            @(negedge clk);
            r = lcg_next();
            tx_stat.valid = r[31];
            tx_stat.sop   = r[7:0];
            tx_stat.eop   = r[15:8];
            tx_stat.err   = r[23:16];
            r = lcg_next();
            rx_stat.valid = r[31];
            rx_stat.sop   = r[7:0];
            rx_stat.eop   = r[15:8];
            rx_stat.err   = r[23:16];
            if (tx_stat.valid) begin
                acc_m[0] = acc_m[0] + 64'(tx_stat.sop);
                acc_m[1] = acc_m[1] + 64'(tx_stat.eop);
                acc_m[2] = acc_m[2] + 64'(tx_stat.err);
            end
            if (rx_stat.valid) begin
                acc_m[3] = acc_m[3] + 64'(rx_stat.sop);
                acc_m[4] = acc_m[4] + 64'(rx_stat.eop);
                acc_m[5] = acc_m[5] + 64'(rx_stat.err);
            end
        end
        @(negedge clk);
        tx_stat = '0;
        rx_stat = '0;
        repeat (3) @(negedge clk);   // accumulators and shadows settle
        settle_model();
    endtask

    // request with base bits 15:8 off by one
    task automatic off_base_probe();
        logic [`PC_ADDR_W-1:0] a;
        bit                    answered;
        a        = reg_addr(CTRL);
        a[15:8]  = a[15:8] + 8'h01;
        answered = 1'b0;
        @(negedge clk);
        status_addr = a;
        status_read = 1'b1;
        repeat (10) begin
            @(negedge clk);
            if (!status_waitrequest || status_readdata_valid)
                answered = 1'b1;
        end
        status_read = 1'b0;
        assert (!answered) else begin
            proto_errs++;
            $display("request outside the base address was answered at %0t", $time);
        end
    endtask

    // --------------------------------------------------
    // compare every read response with the model
    // --------------------------------------------------
    initial begin : compare_rsp
        logic [31:0] exp_v;
        string       nm;
        forever begin
            @(negedge clk);
            if (status_readdata_valid) begin
                assert (exp_q.size() != 0) else begin
                    proto_errs++;
                    $display("read data valid pulse without a read at %0t", $time);
                end
                if (exp_q.size() != 0) begin
                    exp_v = exp_q.pop_front();
                    nm    = name_q.pop_front();
                    check_val(nm, 64'(status_readdata), 64'(exp_v));
                end
            end
        end
    end

    initial begin : watchdog
        #(WD_TIME);
        $display("watchdog expired, the tests did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin : main_seq
        logic [31:0] d;
        rst              = 1'b1;
        status_addr      = '0;
        status_read      = 1'b0;
        status_write     = 1'b0;
        status_writedata = '0;
        tx_stat          = '0;
        rx_stat          = '0;
        value_errs       = 0;
        proto_errs       = 0;
        lcg_state        = 32'd95418;
        cfg_list = '{CTRL, DMAC_HI, DMAC_LO, SMAC_HI, SMAC_LO, PKT_NUM, PKT_SIZE, COLD_RST};
        reset_model();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // reset state
        check_val("o_status_waitrequest", 64'(status_waitrequest), 64'd1);
        check_val("o_status_readdata_valid", 64'(status_readdata_valid), 64'd0);
        check_val("o_stat_cntr_snapshot", 64'(cntr_snapshot), 64'd0);
        check_val("o_stat_cntr_clear", 64'(cntr_clear), 64'd0);
        check_val("o_stat_cnt_clr", 64'(cnt_clr), 64'd0);
        verify_field_outputs();
        foreach (cfg_list[i]) bus_read(cfg_list[i]);
        read_counters();

        // random configuration with the snapshot and clear bits of ctrl off
        foreach (cfg_list[i]) begin
            d = lcg_next();
            if (cfg_list[i] == CTRL)
                d = d & ~32'h0000_01C0;
            bus_write(cfg_list[i], d);
        end
        foreach (cfg_list[i]) bus_read(cfg_list[i]);
        verify_field_outputs();

        // statistics
        drive_beats(60);
        read_counters();

        // snapshot freezes and shadow-clear zeroes
        d = '0;
        d[`PC_CTRL_SNAPSHOT] = 1'b1;
        bus_write(CTRL, d);
        check_val("o_stat_cntr_snapshot", 64'(cntr_snapshot), 64'd1);
        drive_beats(30);
        read_counters();
        bus_write(CTRL, '0);
        read_counters();
        d = '0;
        d[`PC_CTRL_SHADOW_CLR] = 1'b1;
        bus_write(CTRL, d);
        check_val("o_stat_cntr_clear", 64'(cntr_clear), 64'd1);
        read_counters();
        bus_write(CTRL, '0);

        // counter-clear and its self-clear
        d = '0;
        d[`PC_CTRL_CNT_CLR] = 1'b1;
        bus_write(CTRL, d);
        check_val("o_stat_cnt_clr", 64'(cnt_clr), 64'd1);
        repeat (`PC_CLR_HOLD + 2) @(negedge clk);
        check_val("o_stat_cnt_clr", 64'(cnt_clr), 64'd0);
        bus_read(CTRL);
        read_counters();

        // holes in the map and a foreign base
        bus_read(csr_reg_e'(6'h01));
        bus_read(csr_reg_e'(6'h02));
        bus_read(csr_reg_e'(6'h15));
        bus_read(csr_reg_e'(6'h3F));
        off_base_probe();
        repeat (5) @(negedge clk);

        $display("errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
